/* tb.f */
+incdir+src
+incdir+dv
src/io_node_pkg.sv
src/io_decode_stage.sv
src/io_reg_stage.sv
src/io_resp_stage.sv
src/io_node_top.sv
dv/io_node_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module io_node_tb -f tb.f \
	-o io_node_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/io_node_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* dv/io_node_tests.svh */
// ------------------------------------------------------------
// bus helpers
// ------------------------------------------------------------

// byte address of one lane on an i/o page
function automatic logic [31:0] io_addr(input logic [11:0] page, input int lane);
	return {`IO_AREA, page, 3'b000, lane[2:0], 2'b00};
endfunction

// one request cycle, noise on the other lanes
task automatic drive_req(input logic we, input logic [31:0] adr, input logic [3:0] lane_sel,
		input logic [31:0] word, input logic [7:0] tid);
	int lane;
	lane = int'(adr[4:2]);
	req.cyc = 1'b1;
	req.we = we;
	req.adr = adr;
	req.tid = tid;
	req.sel = lcg_next();
	req.sel[lane*4 +: 4] = lane_sel;
	req.dat = {`BUS_LANES{lcg_next()}};
	req.dat[lane*32 +: 32] = word;
endtask

// lone request, waits for ack and checks latency and echo
task automatic single_access(input logic we, input logic [31:0] adr,
		input logic [3:0] lane_sel, input logic [31:0] word, output wb_resp_t rsp);
	int lat;
	logic [7:0] tid;
	tid = next_tid;
	next_tid = next_tid + 8'd1;
	@(negedge node_clk);
	drive_req(we, adr, lane_sel, word, tid);
	@(negedge node_clk);	// one cycle on the bus
	req.cyc = 1'b0;
	lat = 1;
	while (!resp.ack && lat < ACK_TIMEOUT) begin
		@(negedge node_clk);
		lat++;
	end
	assert (resp.ack) else stop_on_error(1'b0, $sformatf("no ack for tid %0d", tid));
	assert (lat == 3) else stop_on_error(1'b1, $sformatf("ack latency %0d, expected 3", lat));
	assert (resp.tid == tid && resp.adr == adr) else
		stop_on_error(1'b1, $sformatf("echo tid %h adr %h, expected %h %h",
			resp.tid, resp.adr, tid, adr));
	rsp = resp;
	@(negedge node_clk);
	assert (!resp.ack) else stop_on_error(1'b1, "ack longer than one cycle");
endtask

// err flag, and the word in all lanes when chk_dat is set
task automatic check_resp(input wb_resp_t rsp, input logic err, input logic [31:0] word,
		input bit chk_dat);
	assert (rsp.err == err) else
		stop_on_error(1'b1, $sformatf("err %0b, expected %0b", rsp.err, err));
	if (chk_dat) begin
		assert (rsp.dat == {`BUS_LANES{word}}) else
			stop_on_error(1'b1, $sformatf("read data %h, expected %h in all lanes",
				rsp.dat, word));
	end
endtask

task automatic check_regs();
	assert (led == led_model) else
		stop_on_error(1'b1, $sformatf("led_o %h, expected %h", led, led_model));
	assert (clken == clken_model) else
		stop_on_error(1'b1, $sformatf("clken_o %b, expected %b", clken, clken_model));
endtask

// ------------------------------------------------------------
// directed tests
// ------------------------------------------------------------

task automatic test_reset_state();
	assert (!resp.ack) else stop_on_error(1'b1, "ack set out of reset");
	assert (rsts == 16'h0000) else stop_on_error(1'b1, $sformatf("rsts_o %h out of reset", rsts));
	check_regs();
endtask

task automatic test_led();
	wb_resp_t rsp;
	logic [31:0] word;
	for (int lane = 1; lane < `BUS_LANES; lane += 2) begin
		word = lcg_next();
		single_access(1'b1, io_addr(`LEDS_PAGE, lane), 4'hF, word, rsp);
		check_resp(rsp, 1'b0, word, 1'b0);
		led_model = word[7:0];	// low byte of the lane
		check_regs();
		single_access(1'b0, io_addr(`LEDS_PAGE, lane), 4'hF, lcg_next(), rsp);
		check_resp(rsp, 1'b0, {24'h0, led_model}, 1'b1);
	end
	word = lcg_next();
	word[7:0] = ~led_model;
	single_access(1'b1, io_addr(`LEDS_PAGE, 2), 4'b1110, word, rsp);	// byte 0 off
	check_regs();
endtask

task automatic test_reset_pulse();
	wb_resp_t rsp;
	logic [31:0] word;
	logic [15:0] mask;
	int seen;
	word = lcg_next();
	word[18:16] = 3'b001;	// clock 2 off, so the wake up shows
	single_access(1'b1, io_addr(`RST_PAGE, 0), 4'b1100, word, rsp);
	clken_model = 3'b001;
	check_regs();
	word = lcg_next();
	word[4] = 1'b1;	// mask bits 5:4 nonzero
	mask = word[15:0];
	single_access(1'b1, io_addr(`RST_PAGE, 4), 4'b0011, word, rsp);
	check_resp(rsp, 1'b0, word, 1'b0);
	clken_model[2] = 1'b1;
	check_regs();
	seen = 3;	// samples after edges N+2 to N+4
	assert (rsts == mask) else stop_on_error(1'b1, $sformatf("rsts_o %h, expected %h", rsts, mask));
	while (rsts != 16'h0000 && seen < PULSE_CYCLES) begin
		@(negedge node_clk);
		if (rsts != 16'h0000) begin
			assert (rsts == mask) else
				stop_on_error(1'b1, $sformatf("rsts_o %h, expected %h", rsts, mask));
			seen++;
		end
	end
	assert (seen == 64) else
		stop_on_error(1'b1, $sformatf("reset pulse of %0d cycles, expected 64", seen));
endtask

task automatic test_clken();
	wb_resp_t rsp;
	logic [31:0] word;
	logic [15:0] mask;
	word = lcg_next();
	word[18] = 1'b0;	// clock 2 off, so a false wake up shows
	clken_model = word[18:16];
	single_access(1'b1, io_addr(`RST_PAGE, 6), 4'b1100, word, rsp);
	check_regs();
	single_access(1'b0, io_addr(`RST_PAGE, 6), 4'hF, lcg_next(), rsp);
	check_resp(rsp, 1'b0, {13'h0, clken_model, 16'h0000}, 1'b1);	// no pulse running
	word = lcg_next();
	word[5:4] = 2'b00;	// no wake up
	word[0] = 1'b1;
	mask = word[15:0];
	single_access(1'b1, io_addr(`RST_PAGE, 2), 4'b0001, word, rsp);
	check_regs();
	single_access(1'b0, io_addr(`RST_PAGE, 2), 4'hF, lcg_next(), rsp);
	check_resp(rsp, 1'b0, {13'h0, clken_model, mask}, 1'b1);	// mid pulse
	for (int n = 0; n < PULSE_CYCLES && rsts != 16'h0000; n++)
		@(negedge node_clk);
	assert (rsts == 16'h0000) else stop_on_error(1'b0, "reset pulse did not end");
	single_access(1'b0, io_addr(`RST_PAGE, 0), 4'hF, lcg_next(), rsp);
	check_resp(rsp, 1'b0, {13'h0, clken_model, 16'h0000}, 1'b1);
endtask

task automatic test_unmapped();
	wb_resp_t rsp;
	logic [31:0] addrs[4];
	addrs[0] = 32'h0000_1000;	// outside the i/o area
	addrs[1] = {12'hFD1, `LEDS_PAGE, 8'h00};	// led page, wrong area
	addrs[2] = io_addr(12'hFFE, 3);	// free page in the area
	addrs[3] = io_addr(12'h000, 5);
	foreach (addrs[i]) begin
		single_access(1'b1, addrs[i], 4'hF, lcg_next(), rsp);
		check_resp(rsp, 1'b1, 32'hFFFF_FFFF, 1'b1);
		check_regs();
		single_access(1'b0, addrs[i], 4'hF, lcg_next(), rsp);
		check_resp(rsp, 1'b1, 32'hFFFF_FFFF, 1'b1);
	end
endtask

// one request per cycle, ack due 3 falling edges after the drive
task automatic test_stream();
	logic [7:0] exp_tid[STREAM_LEN];
	logic [31:0] exp_dat[STREAM_LEN];
	logic exp_rd[STREAM_LEN];
	logic [31:0] r;
	logic [31:0] word;
	int k;
	for (int j = 0; j < STREAM_LEN + 4; j++) begin
		@(negedge node_clk);
		k = j - 3;
		if (k >= 0 && k < STREAM_LEN) begin
			assert (resp.ack && !resp.err && resp.tid == exp_tid[k]) else
				stop_on_error(1'b1, $sformatf("stream %0d ack %b err %b tid %h, expected tid %h",
					k, resp.ack, resp.err, resp.tid, exp_tid[k]));
			if (exp_rd[k]) begin
				check_resp(resp, 1'b0, exp_dat[k], 1'b1);
			end
		end else begin
			assert (!resp.ack) else stop_on_error(1'b1, "ack outside its slot");
		end
		if (j < STREAM_LEN) begin
			r = lcg_next();
			word = lcg_next();
			exp_tid[j] = next_tid;
			exp_rd[j] = !r[0];
			exp_dat[j] = {24'h0, led_model};	// value before this request
			if (r[0] && r[4])
				led_model = word[7:0];
			drive_req(r[0], io_addr(`LEDS_PAGE, int'(r[3:1])), r[7:4], word, next_tid);
			next_tid = next_tid + 8'd1;
		end else begin
			req.cyc = 1'b0;
		end
	end
	check_regs();
endtask

/* dv/io_node_tb.sv */
`timescale 1ns/10ps
`include "io_node_consts.svh"

module io_node_tb import io_node_pkg::*; ();

	localparam int CLK_PERIOD = 100;	// ns
	localparam int ACK_TIMEOUT = 10;	// cycles
	localparam int ACCESS_CYCLES = 6;	// one single access with its idle check
	localparam int PULSE_CYCLES = 70;	// 64 cycle pulse plus slack
	localparam int STREAM_LEN = 32;	// back to back requests
	// 24 single accesses, two pulses, the stream, then margin
	localparam int WATCHDOG_CYCLES = 24 * ACCESS_CYCLES + 2 * PULSE_CYCLES + STREAM_LEN + 100;

	logic node_clk;
	logic rst;
	wb_req_t req;
	wb_resp_t resp;
	logic [7:0] led;
	logic [15:0] rsts;
	logic [2:0] clken;
	logic [31:0] lcg_state;
	logic [7:0] next_tid;
	logic [7:0] led_model;	// led register as expected
	logic [2:0] clken_model;	// clock enables as expected

	io_node_top i_io_node_top (
		.node_clk(node_clk), .rst(rst), .req_i(req), .resp_o(resp),
		.led_o(led), .rsts_o(rsts), .clken_o(clken)
	);

	initial begin
		node_clk = 1'b0;
		forever #(CLK_PERIOD / 2) node_clk = ~node_clk;
	end

	// ------------------------------------------------------------
	// error exit
	// ------------------------------------------------------------

	task automatic stop_on_error(input bit wrong_value, input string msg);
		if (wrong_value)
			$display("MISMATCH at %0t ns: %s", $time, msg);
		else
			$display("ERROR at %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	// numerical recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	`include "io_node_tests.svh"

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		lcg_state = 32'd28503;
		next_tid = 8'h00;
		led_model = 8'h00;
		clken_model = 3'b110;	// value out of reset
		req = '0;
		rst = 1'b1;
		repeat (2) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		test_reset_state();
		test_led();
		test_reset_pulse();
		test_clken();
		test_unmapped();
		test_stream();
		$display("TEST RESULT: PASS");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_on_error(1'b0, $sformatf("timeout, tests not done after %0d cycles",
			WATCHDOG_CYCLES));
	end

endmodule

/* src/io_node_top.sv */
`timescale 1ns/10ps

module io_node_top import io_node_pkg::*; (
	input logic node_clk,
	input logic rst,
	input wb_req_t req_i,
	output wb_resp_t resp_o,
	output logic [7:0] led_o,
	output logic [15:0] rsts_o,
	output logic [2:0] clken_o
);

	io_op_t op;	// decode -> reg
	io_rsp32_t rsp;	// reg -> resp

	// ------------------------------------------------------------
	// three stage i/o pipeline
	// ------------------------------------------------------------

	// stage 1, address decode and lane pick
	io_decode_stage i_io_decode_stage (
		.node_clk(node_clk),
		.rst(rst),
		.req_i(req_i),
		.op_o(op)
	);

	// stage 2, device registers
	io_reg_stage i_io_reg_stage (
		.node_clk(node_clk),
		.rst(rst),
		.op_i(op),
		.rsp_o(rsp),
		.led_o(led_o),
		.rsts_o(rsts_o),
		.clken_o(clken_o)
	);

	// stage 3, back to 256 bits
	io_resp_stage i_io_resp_stage (
		.node_clk(node_clk),
		.rst(rst),
		.rsp_i(rsp),
		.resp_o(resp_o)
	);

endmodule

/* src/io_resp_stage.sv */
`timescale 1ns/10ps
`include "io_node_consts.svh"

module io_resp_stage import io_node_pkg::*; (
	input logic node_clk,
	input logic rst,
	input io_rsp32_t rsp_i,
	output wb_resp_t resp_o
);

	wb_resp_t resp_d;
	wb_resp_t resp_q;	// payload
	logic ack_q;

	// ------------------------------------------------------------
	// widen to the 256-bit bus
	// ------------------------------------------------------------

	always_comb begin
		resp_d.ack = rsp_i.valid;
		resp_d.err = rsp_i.err;
		resp_d.tid = rsp_i.tid;
		resp_d.adr = rsp_i.adr;
		resp_d.dat = {`BUS_LANES{rsp_i.rdat}};	// same word on every lane
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------

	always_ff @(posedge node_clk, posedge rst) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= rsp_i.valid;	// single cycle, follows valid
	end

	always_ff @(posedge node_clk) begin
		resp_q <= resp_d;
	end

	always_comb begin
		resp_o = resp_q;
		resp_o.ack = ack_q;
	end

endmodule

/* src/io_reg_stage.sv */
`timescale 1ns/10ps
`include "io_node_consts.svh"

module io_reg_stage import io_node_pkg::*; (
	input logic node_clk,
	input logic rst,
	input io_op_t op_i,
	output io_rsp32_t rsp_o,
	output logic [7:0] led_o,
	output logic [15:0] rsts_o,
	output logic [2:0] clken_o
);

	localparam int DONE_BIT = `RST_PULSE_BITS - 1;
	localparam logic [`RST_PULSE_BITS-1:0] CNT_SAT = 1 << DONE_BIT;

	logic [7:0] led_q;
	logic [15:0] rst_mask_q;
	logic [2:0] clken_q;
	logic [`RST_PULSE_BITS-1:0] rst_cnt_q;	// pulse length counter
	logic pulse_done;
	logic wr_leds;
	logic wr_rst;
	io_word_u wr_word;
	io_word_u rd_word;
	io_rsp32_t rsp_d;
	io_rsp32_t rsp_q;	// payload
	logic valid_q;

	assign wr_word = op_i.wdat;
	assign wr_leds = op_i.valid & op_i.we & (op_i.dev == dev_leds);
	assign wr_rst = op_i.valid & op_i.we & (op_i.dev == dev_rst);
	assign pulse_done = rst_cnt_q[DONE_BIT];

	// ------------------------------------------------------------
	// device registers
	// ------------------------------------------------------------

	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			led_q <= 8'h00;
			rst_mask_q <= 16'h0000;
			clken_q <= `CLKEN_RESET;
			rst_cnt_q <= CNT_SAT;	// no pulse running
		end else begin
			// pulse timing, counter stops once msb is set
			if (!pulse_done)
				rst_cnt_q <= rst_cnt_q + 1'b1;
			else
				rst_mask_q <= 16'h0000;	// pulse over

			if (wr_leds && op_i.lane_sel[0])
				led_q <= wr_word.led_v.led;

			// writes come last so they win over the pulse logic
			if (wr_rst) begin
				if (|op_i.lane_sel[1:0]) begin
					rst_mask_q <= wr_word.rst_v.rst_mask;
					rst_cnt_q <= '0;	// restart pulse
					// mask bits 5:4 wake clock 2
					clken_q[2] <= clken_q[2] | (|wr_word.rst_v.rst_mask[5:4]);
				end
				if (|op_i.lane_sel[3:2])
					clken_q <= wr_word.rst_v.clken;
			end
		end
	end

	assign led_o = led_q;
	assign clken_o = clken_q;
	assign rsts_o = rst_mask_q & {16{~pulse_done}};	// mask only while counting

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------

	always_comb begin
		rd_word.raw = 32'h0;
		case (op_i.dev)
			dev_leds: rd_word.led_v.led = led_q;	// zero extended
			dev_rst: begin
				rd_word.rst_v.rst_mask = rst_mask_q;
				rd_word.rst_v.clken = clken_q;
			end
			default: rd_word.raw = 32'hFFFF_FFFF;	// unmapped
		endcase
	end

	always_comb begin
		rsp_d.valid = op_i.valid;
		rsp_d.err = op_i.dev == dev_none;
		rsp_d.tid = op_i.tid;
		rsp_d.adr = op_i.adr;
		rsp_d.rdat = rd_word.raw;
	end

	// ------------------------------------------------------------
	// stage register
	// ------------------------------------------------------------

	always_ff @(posedge node_clk, posedge rst) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= op_i.valid;
	end

	always_ff @(posedge node_clk) begin
		rsp_q <= rsp_d;
	end

	always_comb begin
		rsp_o = rsp_q;
		rsp_o.valid = valid_q;
	end

endmodule

/* src/io_decode_stage.sv */
`timescale 1ns/10ps
`include "io_node_consts.svh"

module io_decode_stage import io_node_pkg::*; (
	input logic node_clk,
	input logic rst,
	input wb_req_t req_i,
	output io_op_t op_o
);

	localparam int LANE_BITS = $clog2(`BUS_LANES);

	logic [LANE_BITS-1:0] lane;	// addressed 32-bit lane
	logic [`BUS_LANES-1:0][31:0] dat_lanes;
	logic [`BUS_LANES-1:0][3:0] sel_lanes;
	logic in_io;
	io_dev_e dev;
	io_op_t op_d;
	io_op_t op_q;	// payload
	logic valid_q;

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------

	assign in_io = req_i.adr[31:20] == `IO_AREA;

	always_comb begin
		dev = dev_none;	// anything unmapped
		if (in_io) begin
			case (req_i.adr[19:8])
				`LEDS_PAGE: dev = dev_leds;
				`RST_PAGE: dev = dev_rst;
				default: dev = dev_none;
			endcase
		end
	end

	// ------------------------------------------------------------
	// lane extraction
	// ------------------------------------------------------------

	assign lane = req_i.adr[LANE_BITS+1:2];	// word index within the 256-bit beat
	assign dat_lanes = req_i.dat;
	assign sel_lanes = req_i.sel;

	always_comb begin
		op_d.valid = req_i.cyc;
		op_d.we = req_i.we;
		op_d.dev = dev;
		op_d.lane_sel = sel_lanes[lane];
		op_d.wdat.raw = dat_lanes[lane];
		op_d.tid = req_i.tid;
		op_d.adr = req_i.adr;
	end

	// ------------------------------------------------------------
	// stage register
	// ------------------------------------------------------------

	always_ff @(posedge node_clk, posedge rst) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= req_i.cyc;	// one request per strobe cycle
	end

	always_ff @(posedge node_clk) begin
		op_q <= op_d;
	end

	// valid from the reset flop, rest from payload
	always_comb begin
		op_o = op_q;
		op_o.valid = valid_q;
	end

endmodule

/* src/io_node_pkg.sv */
`include "io_node_consts.svh"

package io_node_pkg;

	// 256-bit bus request, one cycle per request
	typedef struct packed {
		logic cyc;	// request strobe
		logic we;
		logic [`BUS_LANES*4-1:0] sel;	// byte selects
		logic [31:0] adr;
		logic [`BUS_LANES*32-1:0] dat;
		logic [7:0] tid;
	} wb_req_t;

	// 256-bit bus response
	typedef struct packed {
		logic ack;	// one cycle
		logic err;
		logic [7:0] tid;	// echoed
		logic [31:0] adr;	// echoed
		logic [`BUS_LANES*32-1:0] dat;
	} wb_resp_t;

	typedef enum logic [1:0] {
		dev_none,
		dev_leds,
		dev_rst
	} io_dev_e;

	// reset / clock enable control word
	typedef struct packed {
		logic [12:0] rsvd;
		logic [2:0] clken;	// bits 18:16
		logic [15:0] rst_mask;	// bits 15:0
	} rst_ctl_t;

	typedef struct packed {
		logic [23:0] rsvd;
		logic [7:0] led;
	} led_word_t;

	// one register word, two readings
	typedef union packed {
		logic [31:0] raw;
		led_word_t led_v;
		rst_ctl_t rst_v;
	} io_word_u;

	// decode -> register stage
	typedef struct packed {
		logic valid;
		logic we;
		io_dev_e dev;
		logic [3:0] lane_sel;	// byte selects of the chosen lane
		io_word_u wdat;
		logic [7:0] tid;
		logic [31:0] adr;
	} io_op_t;

	// register -> response stage
	typedef struct packed {
		logic valid;
		logic err;
		logic [7:0] tid;
		logic [31:0] adr;
		logic [31:0] rdat;
	} io_rsp32_t;

endpackage

/* src/io_node_consts.svh */
`ifndef IO_NODE_CONSTS_SVH
`define IO_NODE_CONSTS_SVH

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------

// adr[31:20] of the i/o area
`define IO_AREA 12'hFD0

// adr[19:8] pages inside the i/o area
`define LEDS_PAGE 12'hFFF	// led port
`define RST_PAGE 12'hFFC	// reset / clock enable control

// ------------------------------------------------------------
// bus geometry
// ------------------------------------------------------------

`define BUS_LANES 8	// 32-bit lanes per 256-bit data word

// ------------------------------------------------------------
// register defaults
// ------------------------------------------------------------

// pulse counter width, msb flags the end of the pulse (64 cycles)
`define RST_PULSE_BITS 7

`define CLKEN_RESET 3'b110	// clock enables out of reset

`endif
